//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    // Instruction formats in the supported subset
    typedef enum logic [2:0] {
        R_type,
        I_type,
        U_type,
        J_type,
        NONE_type                                       // No register operands at all
    } fmt_e;

    // Operation inside the selected unit
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,                                         // Signed compare
        OP_PASSB,                                       // Result is operand b
        OP_NOP
    } op_e;

    // Execution unit, bypass never writes back
    typedef enum logic [1:0] {
        alu,
        link,                                           // Result is the next PC
        bypass                                          // Bubble or NOP
    } xu_e;

    localparam logic [6:0] OPC_OP    = 7'b0110011;      // Register-register ALU
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;      // Register-immediate ALU
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;

    localparam logic [2:0] F3_ADD = 3'b000;             // Also SUB with F7_SUB
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // Low bit of each instruction field
    localparam int OPC_LSB = 0;                         // 7 bits
    localparam int RD_LSB  = 7;                         // 5 bits
    localparam int F3_LSB  = 12;                        // 3 bits
    localparam int RS1_LSB = 15;                        // 5 bits
    localparam int RS2_LSB = 20;                        // 5 bits
    localparam int F7_LSB  = 25;                        // 7 bits

endpackage

//--- verilog/rv_pipe_pkg.sv
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // One lock entry per stage between issue and register write
    localparam int LOCK_DEPTH = 2;

    // Instruction as presented by the source, 69 bits
    typedef struct packed {
        logic        valid;
        logic [31:0] instruction;
        logic [31:0] npc;                               // Address of the next instruction
        logic [3:0]  tag;
    } fetch_t;

    // Decoded instruction
    typedef struct packed {
        logic        valid;
        logic [31:0] instruction;                       // rd cleared for NOPs
        logic [31:0] npc;
        logic [3:0]  tag;
        fmt_e        fmt;
        op_e         op;
        xu_e         xu;
    } dec_t;

    // Operands and control issued to execute
    typedef struct packed {
        logic [31:0] opa;
        logic [31:0] opb;
        op_e         op;
        xu_e         xu;
        logic [4:0]  rd;
        logic [3:0]  tag;
    } exop_t;

    // Writeback to the register bank, 42 bits
    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [3:0]  tag;
    } wb_t;

    localparam exop_t EXOP_NOP = '{opa: '0, opb: '0, op: OP_NOP, xu: bypass, rd: '0, tag: '0};

endpackage

//--- verilog/instr_decode.sv
module instr_decode import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  fetch_t fetch,
    output dec_t   dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    fmt_e       fmt;
    op_e        op;
    xu_e        xu;

    assign opcode = fetch.instruction[OPC_LSB +: 7];
    assign funct3 = fetch.instruction[F3_LSB +: 3];
    assign funct7 = fetch.instruction[F7_LSB +: 7];

    always_comb begin
        fmt = NONE_type;                                // Default is a NOP
        op  = OP_NOP;
        xu  = bypass;
        if (fetch.valid) begin
            case (opcode)
                OPC_OP: begin
                    if (funct7 == F7_BASE) begin
                        case (funct3)
                            F3_ADD:  op = OP_ADD;
                            F3_SLT:  op = OP_SLT;
                            F3_XOR:  op = OP_XOR;
                            F3_OR:   op = OP_OR;
                            F3_AND:  op = OP_AND;
                            default: op = OP_NOP;       // Shifts and SLTU left out
                        endcase
                    end else if (funct7 == F7_SUB && funct3 == F3_ADD) begin
                        op = OP_SUB;
                    end
                    if (op != OP_NOP) begin
                        fmt = R_type;
                        xu  = alu;
                    end
                end
                OPC_OPIMM: begin
                    case (funct3)
                        F3_ADD:  op = OP_ADD;
                        F3_XOR:  op = OP_XOR;
                        F3_OR:   op = OP_OR;
                        F3_AND:  op = OP_AND;
                        default: op = OP_NOP;           // No SLTI or shift immediates
                    endcase
                    if (op != OP_NOP) begin
                        fmt = I_type;
                        xu  = alu;
                    end
                end
                OPC_LUI: begin
                    fmt = U_type;
                    op  = OP_PASSB;                     // Immediate straight through
                    xu  = alu;
                end
                OPC_AUIPC: begin
                    fmt = U_type;
                    op  = OP_ADD;                       // npc plus immediate
                    xu  = alu;
                end
                OPC_JAL: begin
                    fmt = J_type;
                    op  = OP_NOP;                       // Link unit ignores op
                    xu  = link;
                end
                default: ;                              // Unsupported opcode stays a NOP
            endcase
        end
    end

    always_comb begin
        dec.valid       = fetch.valid;
        dec.instruction = fetch.instruction;
        dec.npc         = fetch.npc;
        dec.tag         = fetch.tag;
        dec.fmt         = fmt;
        dec.op          = op;
        dec.xu          = xu;
        if (xu == bypass)
            dec.instruction[RD_LSB +: 5] = '0;          // A NOP targets x0 and locks nothing
    end

endmodule

//--- verilog/operand_fetch.sv
module operand_fetch import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  dec_t        dec,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output exop_t       ex_in,
    output logic        ready                           // Low while a bubble is issued
);

    logic [4:0]  rd;
    logic [31:0] imm;
    logic [31:0] opa;
    logic [31:0] opb;
    logic        use_rs1;
    logic        use_rs2;
    logic [31:0] rd_mask;                               // One-hot destination
    logic [31:0] push_mask;
    logic [31:0] locked;                                // Registers with a pending write
    logic [31:0] lock_queue [LOCK_DEPTH];

    assign rs1_addr = dec.instruction[RS1_LSB +: 5];    // Straight to the register bank
    assign rs2_addr = dec.instruction[RS2_LSB +: 5];
    assign rd       = dec.instruction[RD_LSB +: 5];

    always_comb begin
        case (dec.fmt)
            I_type:  imm = {{20{dec.instruction[31]}}, dec.instruction[31:20]};
            U_type:  imm = {dec.instruction[31:12], 12'b0};
            J_type:  imm = {{12{dec.instruction[31]}}, dec.instruction[19:12],
                            dec.instruction[20], dec.instruction[30:21], 1'b0};
            default: imm = '0;                          // R and NONE carry no immediate
        endcase
    end

    assign opa = (dec.fmt == U_type || dec.fmt == J_type) ? dec.npc : rs1_data;
    assign opb = (dec.fmt == R_type) ? rs2_data : imm;

    // Only sources the format really reads may stall
    assign use_rs1 = (dec.fmt == R_type) || (dec.fmt == I_type);
    assign use_rs2 = (dec.fmt == R_type);

    always_comb begin
        rd_mask = '0;
        if (dec.xu != bypass)
            rd_mask[rd] = 1'b1;
        rd_mask[0] = 1'b0;                              // x0 is never pending
    end

    assign push_mask = ready ? rd_mask : '0;            // A bubble pushes an empty mask

    always_comb begin
        locked = '0;
        for (int k = 0; k < LOCK_DEPTH; k++)
            locked = locked | lock_queue[k];
    end

    assign ready = !((use_rs1 && locked[rs1_addr]) || (use_rs2 && locked[rs2_addr]));

    // Entry 0 tracks execute, the last entry tracks writeback
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int k = 0; k < LOCK_DEPTH; k++)
                lock_queue[k] <= '0;                    // Nothing locked after reset
        end else begin
            lock_queue[0] <= push_mask;
            for (int k = 1; k < LOCK_DEPTH; k++)
                lock_queue[k] <= lock_queue[k-1];       // Shift one stage per cycle
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ex_in <= EXOP_NOP;
        end else if (!ready) begin
            ex_in <= EXOP_NOP;                          // Bubble turns into a NOP
        end else begin
            ex_in.opa <= opa;
            ex_in.opb <= opb;
            ex_in.op  <= dec.op;
            ex_in.xu  <= dec.xu;
            ex_in.rd  <= rd;
            ex_in.tag <= dec.tag;
        end
    end

    for (genvar g = 0; g < LOCK_DEPTH; g++) begin : g_x0_chk
        a_x0_free: assert property (@(posedge clk) disable iff (!reset)
            lock_queue[g][0] == 1'b0);                  // x0 never enters the queue
    end

    a_bubble_nop: assert property (@(posedge clk) disable iff (!reset)
        !ready |=> ex_in.xu == bypass);

endmodule

//--- verilog/reg_bank.sv
module reg_bank import rv_pipe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  wb_t         wb
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int k = 0; k < 32; k++)
                regs[k] <= '0;
        end else if (wb.we && wb.rd != '0) begin       // x0 stays zero
            regs[wb.rd] <= wb.data;
        end
    end

    // No write-to-read bypass, the lock queue covers the write cycle
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- verilog/execute_unit.sv
module execute_unit import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  exop_t ex_in,
    output wb_t   wb
);

    logic [31:0] result;
    logic        lt;                                    // Signed a < b

    assign lt = $signed(ex_in.opa) < $signed(ex_in.opb);

    always_comb begin
        case (ex_in.op)
            OP_ADD:   result = ex_in.opa + ex_in.opb;
            OP_SUB:   result = ex_in.opa - ex_in.opb;
            OP_AND:   result = ex_in.opa & ex_in.opb;
            OP_OR:    result = ex_in.opa | ex_in.opb;
            OP_XOR:   result = ex_in.opa ^ ex_in.opb;
            OP_SLT:   result = {31'b0, lt};
            OP_PASSB: result = ex_in.opb;               // LUI
            default:  result = '0;
        endcase
        if (ex_in.xu == link)
            result = ex_in.opa;                         // JAL writes npc
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wb <= '0;                                   // No write pending
        end else begin
            wb.we   <= (ex_in.xu != bypass) && (ex_in.rd != '0);
            wb.rd   <= ex_in.rd;
            wb.data <= result;
            wb.tag  <= ex_in.tag;
        end
    end

    a_we_rd: assert property (@(posedge clk) disable iff (!reset)
        wb.we |-> wb.rd != '0);

endmodule

//--- verilog/rv_core_top.sv
module rv_core_top import rv_pipe_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  fetch_t fetch,
    output logic   ready,                               // Source holds fetch while low
    output wb_t    wb
);

    dec_t        dec;
    exop_t       ex_in;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;

    instr_decode u_decode (
        .fetch (fetch),
        .dec   (dec)
    );

    operand_fetch u_opfetch (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .ex_in    (ex_in),
        .ready    (ready)
    );

    execute_unit u_execute (
        .clk   (clk),
        .reset (reset),
        .ex_in (ex_in),
        .wb    (wb)                                     // Also the core's writeback port
    );

    reg_bank u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

endmodule

//--- verification/rv_core_tb.sv
module rv_core_tb import rv_isa_pkg::*, rv_pipe_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS      = 6;
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = 40 * NUM_TESTS + RESET_CYCLES;

    typedef struct packed {
        logic [31:0] due;                               // Cycle the wb must show up
        wb_t         wb;
    } expect_t;

    logic   clk;
    logic   reset;
    fetch_t fetch;
    logic   ready;
    wb_t    wb;

    int          cycle = 0;
    int          error_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    integer      seed = 51667;
    logic [3:0]  tag_count = '0;
    logic [31:0] model_regs [32];                       // Reference register file
    int          free_at [32];                          // First cycle a reader may issue
    expect_t     exp_q [$];                             // Pending writebacks in tag order

    string       test_name [NUM_TESTS];
    int          test_len [NUM_TESTS];
    logic [31:0] test_npc [NUM_TESTS];
    logic [31:0] test_word [NUM_TESTS][8];

    rv_core_top u_dut (
        .clk   (clk),
        .reset (reset),
        .fetch (fetch),
        .ready (ready),
        .wb    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OPIMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                          input logic [4:0] rd);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // ISA rules for the supported subset, anything else writes nothing
    task automatic model_instr(input logic [31:0] w, input logic [31:0] npc,
                               output logic we, output logic [31:0] val,
                               output logic use1, output logic use2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic        hit;
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_u = {w[31:12], 12'h000};
        hit   = 1'b1;
        val   = '0;
        use1  = 1'b0;
        use2  = 1'b0;
        case (w[6:0])
            OPC_OP: begin
                case ({w[31:25], w[14:12]})
                    10'b0000000_000: val = a + b;
                    10'b0100000_000: val = a - b;
                    10'b0000000_010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    10'b0000000_100: val = a ^ b;
                    10'b0000000_110: val = a | b;
                    10'b0000000_111: val = a & b;
                    default:         hit = 1'b0;        // Shifts, SLTU and friends
                endcase
                use1 = hit;
                use2 = hit;
            end
            OPC_OPIMM: begin
                case (w[14:12])
                    3'b000:  val = a + imm_i;
                    3'b100:  val = a ^ imm_i;
                    3'b110:  val = a | imm_i;
                    3'b111:  val = a & imm_i;
                    default: hit = 1'b0;
                endcase
                use1 = hit;
            end
            OPC_LUI:   val = imm_u;
            OPC_AUIPC: val = npc + imm_u;
            OPC_JAL:   val = npc;                       // Link value only, no PC change
            default:   hit = 1'b0;
        endcase
        we = hit && (w[11:7] != 5'd0);
    endtask

    // Present one word, hold it through stalls, check the stall count
    task automatic issue(input logic [31:0] w, input logic [31:0] npc, output int stalls);
        logic        we;
        logic [31:0] val;
        logic        use1;
        logic        use2;
        int          t_first;
        int          pred;
        int          acc;
        fetch <= '{valid: 1'b1, instruction: w, npc: npc, tag: tag_count};
        model_instr(w, npc, we, val, use1, use2);
        t_first = cycle + 1;                            // Earliest acceptance edge
        pred    = 0;
        if (use1 && free_at[w[19:15]] - t_first > pred)
            pred = free_at[w[19:15]] - t_first;
        if (use2 && free_at[w[24:20]] - t_first > pred)
            pred = free_at[w[24:20]] - t_first;
        stalls = 0;
        @(negedge clk);
        while (!ready) begin
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);                                 // Acceptance edge
        acc = cycle;
        a_stall: assert (stalls == pred) else begin
            $display("FAIL %0t: tag %0d stalled %0d cycles, expected %0d",
                     $time, tag_count, stalls, pred);
            error_count++;
        end
        if (we) begin
            model_regs[w[11:7]] = val;
            free_at[w[11:7]]    = acc + 3;              // Lock covers execute and wb
            exp_q.push_back('{due: 32'(acc + 2),
                              wb: '{we: 1'b1, rd: w[11:7], data: val, tag: tag_count}});
        end
        tag_count++;
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (reset && wb.we) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected writeback at %0t ns to x%0d with tag %0d",
                         $time, wb.rd, wb.tag);
                error_count++;
            end else begin
                e = exp_q.pop_front();
                a_tag: assert (wb.tag == e.wb.tag) else begin
                    $display("FAIL %0t: wb tag %0d, expected %0d", $time, wb.tag, e.wb.tag);
                    error_count++;
                end
                a_rd: assert (wb.rd == e.wb.rd) else begin
                    $display("FAIL %0t: tag %0d wrote x%0d, expected x%0d",
                             $time, e.wb.tag, wb.rd, e.wb.rd);
                    error_count++;
                end
                a_data: assert (wb.data == e.wb.data) else begin
                    $display("FAIL %0t: tag %0d data %h, expected %h",
                             $time, e.wb.tag, wb.data, e.wb.data);
                    error_count++;
                end
                a_due: assert (32'(cycle) == e.due) else begin
                    $display("FAIL %0t: tag %0d wb in cycle %0d, expected %0d",
                             $time, e.wb.tag, cycle, e.due);
                    error_count++;
                end
            end
        end
    end

    task automatic add_word(input int t, input logic [31:0] w);
        test_word[t][test_len[t]] = w;
        test_len[t]++;
    endtask

    task automatic build_table();
        int         r;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_len[t] = 0;
            test_npc[t] = 32'h0000_1000 + 32'(t) * 32'h100;
        end
        test_name[0] = "addi_const";                    // Independent, no stalls
        add_word(0, enc_i(12'd5, 5'd0, F3_ADD, 5'd1));
        add_word(0, enc_i(12'hFFD, 5'd0, F3_ADD, 5'd2));
        add_word(0, enc_i(12'h7FF, 5'd0, F3_ADD, 5'd3));
        add_word(0, enc_i(12'h800, 5'd0, F3_ADD, 5'd4));
        add_word(0, enc_i(12'h123, 5'd0, F3_ADD, 5'd5));
        add_word(0, enc_i(12'hFFF, 5'd0, F3_ADD, 5'd6));
        test_name[1] = "r_type";
        add_word(1, enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd7));
        add_word(1, enc_r(F7_SUB, 5'd2, 5'd1, F3_ADD, 5'd8));
        add_word(1, enc_r(F7_BASE, 5'd6, 5'd3, F3_AND, 5'd9));
        add_word(1, enc_r(F7_BASE, 5'd4, 5'd1, F3_OR, 5'd10));
        add_word(1, enc_r(F7_BASE, 5'd6, 5'd3, F3_XOR, 5'd11));
        add_word(1, enc_r(F7_BASE, 5'd1, 5'd2, F3_SLT, 5'd12));   // -3 < 5
        add_word(1, enc_r(F7_BASE, 5'd2, 5'd4, F3_SLT, 5'd13));   // Both negative
        add_word(1, enc_r(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd14));
        test_name[2] = "upper_jal";
        add_word(2, enc_u(OPC_LUI, 20'hABCDE, 5'd15));
        add_word(2, enc_u(OPC_AUIPC, 20'h00012, 5'd16));
        add_word(2, enc_j(21'h000100, 5'd17));
        add_word(2, enc_j(21'h1FFFF0, 5'd18));          // Backward jump
        add_word(2, enc_u(OPC_LUI, 20'h80000, 5'd19));
        test_name[3] = "hazards";
        add_word(3, enc_i(12'd100, 5'd0, F3_ADD, 5'd20));
        add_word(3, enc_i(12'd7, 5'd20, F3_ADD, 5'd21));  // Back to back, 2 stalls
        add_word(3, enc_i(12'hFFB, 5'd0, F3_ADD, 5'd22));
        add_word(3, enc_i(12'd1, 5'd0, F3_XOR, 5'd24));
        add_word(3, enc_r(F7_SUB, 5'd21, 5'd22, F3_ADD, 5'd23));  // One between, 1 stall
        add_word(3, enc_r(F7_BASE, 5'd23, 5'd0, F3_ADD, 5'd25));  // Via rs2
        test_name[4] = "x0_unsup";
        add_word(4, enc_i(12'd55, 5'd1, F3_ADD, 5'd0));
        add_word(4, enc_i(12'd9, 5'd0, F3_ADD, 5'd26));
        add_word(4, {12'd0, 5'd1, 3'b010, 5'd1, 7'b0000011});    // Load, unsupported
        add_word(4, enc_r(F7_BASE, 5'd1, 5'd1, 3'b001, 5'd2));    // Shift, unsupported
        add_word(4, enc_r(F7_BASE, 5'd0, 5'd1, F3_ADD, 5'd27));
        add_word(4, enc_i(12'd1, 5'd26, F3_ADD, 5'd28));
        test_name[5] = "random";
        for (int i = 0; i < 8; i++) begin
            rd  = 5'(1 + ($random(seed) & 7));          // Small register set forces hazards
            rs1 = 5'(1 + ($random(seed) & 7));
            rs2 = 5'(1 + ($random(seed) & 7));
            r   = $random(seed);
            case (r & 7)
                0, 1:    add_word(5, enc_i(12'(r >>> 8), rs1, F3_ADD, rd));
                2:       add_word(5, enc_r(F7_BASE, rs2, rs1, F3_ADD, rd));
                3:       add_word(5, enc_r(F7_SUB, rs2, rs1, F3_ADD, rd));
                4:       add_word(5, enc_r(F7_BASE, rs2, rs1, F3_SLT, rd));
                5:       add_word(5, enc_r(F7_BASE, rs2, rs1, F3_XOR, rd));
                6:       add_word(5, enc_i(12'(r >>> 8), rs1, F3_AND, rd));
                default: add_word(5, enc_r(F7_BASE, rs2, rs1, F3_OR, rd));
            endcase
        end
    endtask

    task automatic run_test(input int t);
        int errors_before;
        int stalls;
        int stalls_total;
        int waited;
        errors_before = error_count;
        stalls_total  = 0;
        for (int i = 0; i < test_len[t]; i++) begin
            issue(test_word[t][i], test_npc[t] + 32'(4 * (i + 1)), stalls);
            stalls_total += stalls;
        end
        fetch  <= '0;                                   // Source goes idle
        waited = 0;
        while (exp_q.size() != 0 && waited < 6) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("Writeback missing for %0d instruction(s) of test %s",
                     exp_q.size(), test_name[t]);
            error_count++;
            exp_q.delete();
        end
        if (error_count == errors_before) begin
            tests_passed++;
            $display("%-11s passed, %0d stall cycles", test_name[t], stalls_total);
        end else begin
            tests_failed++;
            $display("%-11s failed with %0d errors", test_name[t], error_count - errors_before);
        end
    endtask

    initial begin
        reset = 1'b0;
        fetch = '0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
            free_at[k]    = 0;
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Hang guard
    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Run hung, no finish after %0d cycles", cycle);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- all.f
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/instr_decode.sv
verilog/operand_fetch.sv
verilog/reg_bank.sv
verilog/execute_unit.sv
verilog/rv_core_top.sv
verification/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/rv_pipe_pkg.sv
  - verilog/instr_decode.sv
  - verilog/operand_fetch.sv
  - verilog/reg_bank.sv
  - verilog/execute_unit.sv
  - verilog/rv_core_top.sv
  - target: test
    files:
      - verification/rv_core_tb.sv
